//--- verilog.f
+incdir+src
src/ti_pkg.sv
src/inject_ctrl.sv
src/flit_counter.sv
src/alloc_header.sv
src/task_injector.sv
dv/task_injector_checker.sv
dv/tb_task_injector.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        ?= tb_task_injector
RTL_TOP    ?= task_injector
FILELIST   ?= verilog.f
OBJ_DIR    ?= obj_dir

SIM_FLAGS  ?= --binary --timing --assert --timescale 1ns/1ps -j 0
LINT_FLAGS ?= --lint-only -Wall --timing --timescale 1ns/1ps

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# the exit status of the simulation is the test result.
run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

//--- dv/tb_task_injector.sv
`timescale 1ns/1ps
`include "ti_settings.svh"

module tb_task_injector;

    localparam int unsigned NUM_APPS = 3;

    logic                     clk_i;
    logic                     rst_ni;
    logic                     src_rx_i;
    logic                     src_credit_o;
    logic [`TI_FLIT_SIZE-1:0] src_data_i;
    logic [15:0]              mapper_address_i;
    logic                     noc_tx_o;
    logic                     noc_credit_i;
    logic [`TI_FLIT_SIZE-1:0] noc_data_o;

    logic [31:0]              rng_state;
    logic [`TI_FLIT_SIZE-1:0] src_q[$]; // source stream in order.
    logic [15:0]              map_q[$]; // mapper address that goes with each source flit.
    logic [`TI_FLIT_SIZE-1:0] exp_q[$];
    int unsigned              src_ptr;
    int unsigned              total_flits;
    int unsigned              watchdog_cycles;
    logic                     model_ready;

    task_injector i_dut (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .src_rx_i         (src_rx_i),
        .src_credit_o     (src_credit_o),
        .src_data_i       (src_data_i),
        .mapper_address_i (mapper_address_i),
        .noc_tx_o         (noc_tx_o),
        .noc_credit_i     (noc_credit_i),
        .noc_data_o       (noc_data_o)
    );

    bind task_injector task_injector_checker i_checker (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .src_credit_i (src_credit_o),
        .noc_tx_i     (noc_tx_o),
        .noc_credit_i (noc_credit_i),
        .noc_data_i   (noc_data_o),
        .hdr_done_i   (hdr_done)
    );

    always #4 clk_i = ~clk_i;

    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    function automatic logic chance(input int unsigned percent);
        return (next_rand() % 32'd100) < percent;
    endfunction

    task automatic push_src(input logic [31:0] word, input logic [15:0] map);
        src_q.push_back(word);
        map_q.push_back(map);
    endtask

    // one task with its source flits and the allocation packet it should produce.
    task automatic add_task(input logic [7:0] app_id, input logic [7:0] idx,
                            input logic force_empty);
        logic [31:0] target;
        logic [31:0] txt_sz;
        logic [31:0] data_sz;
        logic [31:0] bss_sz;
        logic [31:0] entry;
        logic [31:0] words;
        logic [31:0] pay;
        logic [31:0] code;
        logic [15:0] map;
        int unsigned i;
        target  = next_rand();
        txt_sz  = force_empty ? 32'd0 : (next_rand() % 32'd16) << 2;
        data_sz = force_empty ? 32'd0 : (next_rand() % 32'd16) << 2;
        bss_sz  = next_rand() % 32'd4096;
        entry   = next_rand();
        map     = 16'(next_rand());
        words   = (txt_sz + data_sz) / 32'd4;
        pay     = words + `TI_HEADER_SIZE - 2;
        push_src(target, ~map);
        push_src(txt_sz, map); // the mapper address is sampled with this flit.
        push_src(data_sz, ~map);
        push_src(bss_sz, ~map);
        push_src(entry, ~map);
        exp_q.push_back(target);
        exp_q.push_back(pay);
        exp_q.push_back(`TI_TASK_ALLOCATION);
        exp_q.push_back({16'h0, app_id, idx});
        exp_q.push_back({16'h0, map});
        repeat (3)
            exp_q.push_back(32'h0);
        exp_q.push_back(`TI_MAPPER_ID);
        exp_q.push_back(data_sz);
        exp_q.push_back(txt_sz);
        exp_q.push_back(bss_sz);
        exp_q.push_back(entry);
        for (i = 0; i < words; i++) begin
            code = next_rand();
            push_src(code, ~map);
            exp_q.push_back(code);
        end
    endtask

    task automatic build_model();
        logic [7:0]  app_id;
        int unsigned cnt;
        int unsigned a;
        int unsigned t;
        for (a = 0; a < NUM_APPS; a++) begin
            app_id = 8'(next_rand());
            cnt    = 32'd1 + next_rand() % 32'd4;
            if (a == 1)
                push_src({15'h0, 8'(next_rand()), 9'h0}, 16'h0); // empty application.
            push_src({15'h0, app_id, 9'(cnt)}, 16'h0);
            for (t = 0; t < cnt; t++)
                add_task(app_id, 8'(t), a == 0 && t == 0);
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        assert (actual === expected) else begin
            $display("FAILED at %0t: %s expected %h, actual %h", $time, name, expected, actual);
            $display("test failed");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    task automatic drive_inputs();
        if (src_ptr < src_q.size()) begin
            src_rx_i         <= !chance(30);
            src_data_i       <= src_q[src_ptr];
            mapper_address_i <= map_q[src_ptr];
        end else begin
            src_rx_i <= 1'b0;
        end
        noc_credit_i <= !chance(30);
    endtask

    task automatic sample_outputs();
        logic [31:0] expected;
        if (src_rx_i && src_credit_o)
            src_ptr++;
        if (noc_tx_o && noc_credit_i) begin
            assert (exp_q.size() != 0) else begin
                $display("a flit left on the NoC at %0t when no packet was expected", $time);
                $display("test failed");
                $fatal(1, "extra NoC flit");
            end
            expected = exp_q.pop_front();
            check_value("noc_data_o", noc_data_o, expected);
        end
    endtask

    initial begin
        wait (model_ready);
        repeat (watchdog_cycles) @(posedge clk_i);
        $display("test failed");
        $fatal(1, "timeout: the packets were not all sent within %0d cycles", watchdog_cycles);
    end

    initial begin
        clk_i            = 1'b0;
        rst_ni           = 1'b0;
        src_rx_i         = 1'b0;
        src_data_i       = '0;
        mapper_address_i = '0;
        noc_credit_i     = 1'b0;
        rng_state        = 32'd78;
        src_ptr          = 0;
        model_ready      = 1'b0;
        build_model();
        total_flits      = exp_q.size();
        watchdog_cycles  = 40 * total_flits + 20;
        model_ready      = 1'b1;

        repeat (5) @(posedge clk_i);
        rst_ni <= 1'b1;
        @(negedge clk_i);
        check_value("noc_tx_o", 32'(noc_tx_o), 32'd0);
        check_value("src_credit_o", 32'(src_credit_o), 32'd1);

        while (src_ptr < src_q.size() || exp_q.size() != 0) begin
            @(posedge clk_i);
            drive_inputs();
            @(negedge clk_i);
            sample_outputs();
        end
        // nothing may follow the last packet.
        repeat (20) begin
            @(posedge clk_i);
            drive_inputs();
            @(negedge clk_i);
            sample_outputs();
        end
        check_value("src_credit_o", 32'(src_credit_o), 32'd1); // idle again.
        $display("test passed");
        $finish;
    end

endmodule

//--- dv/task_injector_checker.sv
`timescale 1ns/1ps
`include "ti_settings.svh"

module task_injector_checker (
    input logic                     clk_i,
    input logic                     rst_ni,
    input logic                     src_credit_i,
    input logic                     noc_tx_i,
    input logic                     noc_credit_i,
    input logic [`TI_FLIT_SIZE-1:0] noc_data_i,
    input logic                     hdr_done_i
);

    // the first clock after reset release finds the injector idle.
    reset_idle_a: assert property (@(posedge clk_i)
        $rose(rst_ni) |-> !noc_tx_i && src_credit_i)
        else $error("NoC output active or source blocked right after reset");

    // header flits come from the registers, so the source must wait.
    header_holds_src_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        noc_tx_i && !hdr_done_i |-> !src_credit_i)
        else $error("source credited while a header flit is on the NoC");

    header_stable_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        noc_tx_i && !noc_credit_i && !hdr_done_i |=> $stable(noc_data_i))
        else $error("header flit changed while waiting for NoC credit");

endmodule

//--- src/task_injector.sv
`timescale 1ns/1ps
`include "ti_settings.svh"

module task_injector (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  logic                     src_rx_i,
    output logic                     src_credit_o,
    input  logic [`TI_FLIT_SIZE-1:0] src_data_i,
    input  logic [15:0]              mapper_address_i,
    output logic                     noc_tx_o,
    input  logic                     noc_credit_i,
    output logic [`TI_FLIT_SIZE-1:0] noc_data_o
);

    ti_pkg::inject_state_e    state;
    logic                     src_take;
    logic                     packet_start;
    logic [3:0]               hdr_idx;
    logic                     hdr_done;
    logic                     pkt_done;
    logic                     code_empty;
    logic [`TI_FLIT_SIZE-1:0] pkt_len;

    inject_ctrl i_inject_ctrl (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .src_rx_i       (src_rx_i),
        .noc_credit_i   (noc_credit_i),
        .app_word_i     (src_data_i),
        .hdr_done_i     (hdr_done),
        .pkt_done_i     (pkt_done),
        .code_empty_i   (code_empty),
        .state_o        (state),
        .src_take_o     (src_take),
        .packet_start_o (packet_start),
        .src_credit_o   (src_credit_o),
        .noc_tx_o       (noc_tx_o)
    );

    // counts on the NoC handshake as seen at the output port.
    flit_counter i_flit_counter (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .packet_start_i (packet_start),
        .noc_tx_i       (noc_tx_o),
        .noc_credit_i   (noc_credit_i),
        .pkt_len_i      (pkt_len),
        .hdr_idx_o      (hdr_idx),
        .hdr_done_o     (hdr_done),
        .pkt_done_o     (pkt_done)
    );

    alloc_header i_alloc_header (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .state_i          (state),
        .src_take_i       (src_take),
        .src_data_i       (src_data_i),
        .mapper_address_i (mapper_address_i),
        .hdr_idx_i        (hdr_idx),
        .hdr_done_i       (hdr_done),
        .pkt_len_o        (pkt_len),
        .code_empty_o     (code_empty),
        .noc_data_o       (noc_data_o)
    );

endmodule

//--- src/alloc_header.sv
`timescale 1ns/1ps
`include "ti_settings.svh"

module alloc_header (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  ti_pkg::inject_state_e    state_i,
    input  logic                     src_take_i,
    input  logic [`TI_FLIT_SIZE-1:0] src_data_i,
    input  logic [15:0]              mapper_address_i,
    input  logic [3:0]               hdr_idx_i,
    input  logic                     hdr_done_i,
    output logic [`TI_FLIT_SIZE-1:0] pkt_len_o,
    output logic                     code_empty_o,
    output logic [`TI_FLIT_SIZE-1:0] noc_data_o
);

    ti_pkg::app_word_u        app_word;
    logic [`TI_APP_ID_W-1:0]  app_id_q;
    logic [7:0]               task_idx_q;
    logic [`TI_FLIT_SIZE-1:0] target_q;
    logic [`TI_FLIT_SIZE-1:0] pay_size_q;
    logic [`TI_FLIT_SIZE-1:0] txt_sz_q;
    logic [`TI_FLIT_SIZE-1:0] data_sz_q;
    logic [`TI_FLIT_SIZE-1:0] bss_sz_q;
    logic [`TI_FLIT_SIZE-1:0] entry_q;
    logic [15:0]              mapper_addr_q;
    logic [`TI_FLIT_SIZE-1:0] hdr_flit;

    assign app_word.raw = src_data_i;

    // task numbering restarts with every application.
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            task_idx_q <= '0;
        end else if (state_i == ti_pkg::IDLE) begin
            task_idx_q <= '0;
        end else if (state_i == ti_pkg::NEXT_TASK) begin
            task_idx_q <= task_idx_q + 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (src_take_i) begin
            case (state_i)
                ti_pkg::IDLE:
                    app_id_q <= app_word.fields.app_id;
                ti_pkg::RECV_TARGET:
                    target_q <= src_data_i;
                ti_pkg::RECV_TXT: begin
                    txt_sz_q      <= src_data_i;
                    pay_size_q    <= src_data_i; // size in bytes until RECV_BSS.
                    mapper_addr_q <= mapper_address_i;
                end
                ti_pkg::RECV_DATA: begin
                    data_sz_q  <= src_data_i;
                    pay_size_q <= pay_size_q + src_data_i;
                end
                ti_pkg::RECV_BSS: begin
                    bss_sz_q   <= src_data_i;
                    pay_size_q <= pay_size_q >> 2; // bytes to code words.
                end
                ti_pkg::RECV_ENTRY: begin
                    entry_q    <= src_data_i;
                    pay_size_q <= pay_size_q + (`TI_HEADER_SIZE - 2);
                end
                default: ;
            endcase
        end
    end

    // the payload size excludes the target and size flits.
    assign pkt_len_o    = pay_size_q + 32'd2;
    assign code_empty_o = (pay_size_q == `TI_HEADER_SIZE - 2);

    always_comb begin
        case (hdr_idx_i)
            4'd0:    hdr_flit = target_q;
            4'd1:    hdr_flit = pay_size_q;
            4'd2:    hdr_flit = `TI_TASK_ALLOCATION;
            4'd3:    hdr_flit = {16'b0, app_id_q, task_idx_q};
            4'd4:    hdr_flit = {16'b0, mapper_addr_q};
            4'd8:    hdr_flit = `TI_MAPPER_ID;
            4'd9:    hdr_flit = data_sz_q;
            4'd10:   hdr_flit = txt_sz_q;
            4'd11:   hdr_flit = bss_sz_q;
            4'd12:   hdr_flit = entry_q;
            default: hdr_flit = '0; // flits 5 to 7 are unused by allocation.
        endcase
    end

    assign noc_data_o = hdr_done_i ? src_data_i : hdr_flit;

endmodule

//--- src/flit_counter.sv
`timescale 1ns/1ps
`include "ti_settings.svh"

module flit_counter (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  logic                     packet_start_i,
    input  logic                     noc_tx_i,
    input  logic                     noc_credit_i,
    input  logic [`TI_FLIT_SIZE-1:0] pkt_len_i,
    output logic [3:0]               hdr_idx_o,
    output logic                     hdr_done_o,
    output logic                     pkt_done_o
);

    logic [`TI_FLIT_SIZE-1:0] sent_q;
    logic                     xfer;

    assign xfer = noc_tx_i && noc_credit_i;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            sent_q <= '0;
        end else if (packet_start_i) begin
            sent_q <= '0;
        end else if (xfer) begin
            sent_q <= sent_q + 1'b1;
        end
    end

    // the index parks on TI_HEADER_SIZE once all header flits are out.
    assign hdr_done_o = (sent_q >= `TI_HEADER_SIZE);
    assign hdr_idx_o  = hdr_done_o ? 4'(`TI_HEADER_SIZE) : sent_q[3:0];

    assign pkt_done_o = xfer && (sent_q == pkt_len_i - 1'b1); // final flit of the packet.

endmodule

//--- src/inject_ctrl.sv
`timescale 1ns/1ps
`include "ti_settings.svh"

module inject_ctrl (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  logic                  src_rx_i,
    input  logic                  noc_credit_i,
    input  ti_pkg::app_word_u     app_word_i,
    input  logic                  hdr_done_i,
    input  logic                  pkt_done_i,
    input  logic                  code_empty_i,
    output ti_pkg::inject_state_e state_o,
    output logic                  src_take_o,
    output logic                  packet_start_o,
    output logic                  src_credit_o,
    output logic                  noc_tx_o
);

    ti_pkg::inject_state_e     state_q;
    ti_pkg::inject_state_e     state_d;
    logic [`TI_TASK_CNT_W-1:0] task_cnt_q;
    logic [`TI_TASK_CNT_W-1:0] task_idx_q;
    logic                      recv_phase;
    logic                      hdr_phase;
    logic                      pay_phase;

    assign recv_phase = state_q inside {
        ti_pkg::IDLE,
        ti_pkg::RECV_TARGET,
        ti_pkg::RECV_TXT,
        ti_pkg::RECV_DATA,
        ti_pkg::RECV_BSS,
        ti_pkg::RECV_ENTRY
    };

    // hdr_done is seen one cycle after the last header transfer, so that
    // cycle of SEND_HEADER already passes code words through.
    assign hdr_phase = (state_q == ti_pkg::SEND_HEADER) && !hdr_done_i;
    assign pay_phase = (state_q == ti_pkg::SEND_PAYLOAD)
                    || (state_q == ti_pkg::SEND_HEADER && hdr_done_i && !code_empty_i);

    assign src_credit_o   = recv_phase || (pay_phase && noc_credit_i);
    assign noc_tx_o       = hdr_phase || (pay_phase && src_rx_i);
    assign src_take_o     = src_rx_i && src_credit_o;
    assign packet_start_o = (state_q == ti_pkg::RECV_ENTRY) && src_take_o;
    assign state_o        = state_q;

    always_comb begin
        state_d = state_q;
        case (state_q)
            ti_pkg::IDLE:
                if (src_take_o && app_word_i.fields.task_cnt != '0)
                    state_d = ti_pkg::RECV_TARGET; // an empty application is dropped here.
            ti_pkg::RECV_TARGET:
                if (src_take_o)
                    state_d = ti_pkg::RECV_TXT;
            ti_pkg::RECV_TXT:
                if (src_take_o)
                    state_d = ti_pkg::RECV_DATA;
            ti_pkg::RECV_DATA:
                if (src_take_o)
                    state_d = ti_pkg::RECV_BSS;
            ti_pkg::RECV_BSS:
                if (src_take_o)
                    state_d = ti_pkg::RECV_ENTRY;
            ti_pkg::RECV_ENTRY:
                if (src_take_o)
                    state_d = ti_pkg::SEND_HEADER;
            ti_pkg::SEND_HEADER: begin
                // pkt_done here is either the last header flit of a task
                // without code or a single code word that goes out at once.
                if (pkt_done_i)
                    state_d = ti_pkg::NEXT_TASK;
                else if (hdr_done_i)
                    state_d = ti_pkg::SEND_PAYLOAD;
            end
            ti_pkg::SEND_PAYLOAD:
                if (pkt_done_i)
                    state_d = ti_pkg::NEXT_TASK;
            ti_pkg::NEXT_TASK:
                state_d = (task_idx_q == task_cnt_q - 1'b1) ? ti_pkg::IDLE
                                                            : ti_pkg::RECV_TARGET;
            default:
                state_d = ti_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q    <= ti_pkg::IDLE;
            task_cnt_q <= '0;
            task_idx_q <= '0;
        end else begin
            state_q <= state_d;
            if (state_q == ti_pkg::IDLE && src_take_o)
                task_cnt_q <= app_word_i.fields.task_cnt;
            if (state_q == ti_pkg::IDLE)
                task_idx_q <= '0;
            else if (state_q == ti_pkg::NEXT_TASK)
                task_idx_q <= task_idx_q + 1'b1;
        end
    end

endmodule

//--- src/ti_pkg.sv
`include "ti_settings.svh"

package ti_pkg;

    // one-hot, so that every phase test is a single bit.
    typedef enum logic [8:0] {
        IDLE         = 9'b0_0000_0001,
        RECV_TARGET  = 9'b0_0000_0010,
        RECV_TXT     = 9'b0_0000_0100,
        RECV_DATA    = 9'b0_0000_1000,
        RECV_BSS     = 9'b0_0001_0000,
        RECV_ENTRY   = 9'b0_0010_0000,
        SEND_HEADER  = 9'b0_0100_0000,
        SEND_PAYLOAD = 9'b0_1000_0000,
        NEXT_TASK    = 9'b1_0000_0000
    } inject_state_e;

    typedef struct packed {
        logic [`TI_FLIT_SIZE-`TI_APP_ID_W-`TI_TASK_CNT_W-1:0] rsvd;
        logic [`TI_APP_ID_W-1:0]                              app_id;
        logic [`TI_TASK_CNT_W-1:0]                            task_cnt;
    } app_fields_t;

    // the application word as it arrives on the source bus.
    typedef union packed {
        logic [`TI_FLIT_SIZE-1:0] raw;
        app_fields_t              fields;
    } app_word_u;

endpackage

//--- src/ti_settings.svh
`ifndef TI_SETTINGS_SVH
`define TI_SETTINGS_SVH

`define TI_FLIT_SIZE 32

// an allocation packet always carries this many header flits.
`define TI_HEADER_SIZE 13

`define TI_TASK_ALLOCATION 32'h0000_0040

`define TI_TASK_CNT_W 9
`define TI_APP_ID_W 8

`define TI_MAPPER_ID 32'h0000_0000 // mapper task id reported in header flit 8.

`endif
